/* dv/fetch_chk.sv */
`include "fetch_consts.svh"

module fetch_chk (
  input logic             clk,
  input logic             reset,
  input logic             stall,
  input logic             redirect,
  input logic             pred_taken,
  input fetch_pkg::addr_t pc
);
  timeunit 1ns;
  timeprecision 100ps;

  int fail_count;

  initial fail_count = 0;

  property p_quiet_after_reset;
    @(posedge clk) $fell(reset) |-> !redirect; // nothing resolved yet
  endproperty

  property p_seq_step;
    @(posedge clk) disable iff (reset)
      (!stall && !redirect && !pred_taken) |=> (pc == $past(pc) + `ADDR_WIDTH'd4);
  endproperty

  property p_stall_hold;
    @(posedge clk) disable iff (reset)
      (stall && !redirect) |=> $stable(pc);
  endproperty

  a_quiet_after_reset: assert property (p_quiet_after_reset)
    else begin
      $error("redirect high in the first cycle after reset");
      fail_count++;
    end

  a_seq_step: assert property (p_seq_step)
    else begin
      $error("pc did not advance by four on a plain fetch");
      fail_count++;
    end

  a_stall_hold: assert property (p_stall_hold)
    else begin
      $error("pc moved during stall without redirect");
      fail_count++;
    end

endmodule

bind fetch_top fetch_chk u_chk (
  .clk        (clk),
  .reset      (reset),
  .stall      (stall),
  .redirect   (redirect),
  .pred_taken (pred_taken),
  .pc         (pc)
);

/* dv/fetch_tb.sv */
`include "fetch_consts.svh"

module fetch_tb;
  timeunit 1ns;
  timeprecision 100ps;
  import fetch_pkg::*;

  localparam int RESET_CYCLES = 16;
  localparam int WAIT_LIMIT   = 20;

  typedef struct packed {
    logic          stall;
    logic          exp_redirect; // redirect expected while this row is applied
    logic          valid;
    resolve_kind_e kind;
    addr_t         pc;
    addr_t         target;
    logic          pred_taken;
    addr_t         pred_target;
  } row_t;

  logic          clk;
  logic          reset;
  logic          stall;
  logic          resolve_valid;
  resolve_kind_e resolve_kind;
  addr_t         resolve_pc;
  addr_t         resolve_target;
  logic          resolve_pred_taken;
  addr_t         resolve_pred_target;
  addr_t         pc;
  logic          pred_taken;
  addr_t         pred_target;
  logic          redirect;
  addr_t         redirect_pc;

  row_t  rows[$];
  int    errors;

  // reference model state
  addr_t m_pc;
  addr_t m_keys    [`BTB_ENTRIES];
  addr_t m_targets [`BTB_ENTRIES];
  logic  m_valid   [`BTB_ENTRIES];
  int    m_ptr;
  logic  m_res_valid;
  row_t  m_res;

  fetch_top uut (
    .clk                 (clk),
    .reset               (reset),
    .stall               (stall),
    .resolve_valid       (resolve_valid),
    .resolve_kind        (resolve_kind),
    .resolve_pc          (resolve_pc),
    .resolve_target      (resolve_target),
    .resolve_pred_taken  (resolve_pred_taken),
    .resolve_pred_target (resolve_pred_target),
    .pc                  (pc),
    .pred_taken          (pred_taken),
    .pred_target         (pred_target),
    .redirect            (redirect),
    .redirect_pc         (redirect_pc)
  );

  always #4 clk = ~clk;

  task automatic add_row(input logic stl, input logic rd, input logic vld,
                         input resolve_kind_e kind, input addr_t rpc, input addr_t tgt,
                         input logic ptk, input addr_t ptgt);
    row_t r;
    r.stall        = stl;
    r.exp_redirect = rd;
    r.valid        = vld;
    r.kind         = kind;
    r.pc           = rpc;
    r.target       = tgt;
    r.pred_taken   = ptk;
    r.pred_target  = ptgt;
    rows.push_back(r);
  endtask

  task automatic add_branch(input logic rd, input resolve_kind_e kind, input addr_t rpc,
                            input addr_t tgt, input logic ptk, input addr_t ptgt);
    add_row(1'b0, rd, 1'b1, kind, rpc, tgt, ptk, ptgt);
  endtask

  task automatic add_idle(input int n, input logic stl, input logic rd_first);
    for (int k = 0; k < n; k++) begin
      add_row(stl, (k == 0) ? rd_first : 1'b0, 1'b0, res_none, '0, '0, 1'b0, '0);
    end
  endtask

  // valid slots that carry no branch
  task automatic add_filler(input int n);
    for (int k = 0; k < n; k++) begin
      add_row(1'b0, 1'b0, 1'b1, res_none, addr_t'($urandom()), addr_t'($urandom()),
              1'b0, '0);
    end
  endtask

  task automatic build_table();
    add_idle(4, 1'b0, 1'b0);
    add_idle(3, 1'b1, 1'b0);
    add_filler(3);
    add_branch(1'b0, res_taken, 32'h200, 32'h800, 1'b0, '0); // learn 0x200
    add_idle(2, 1'b0, 1'b1);
    add_branch(1'b0, res_taken, 32'h300, 32'h200, 1'b0, '0); // steer fetch to 0x200
    add_idle(4, 1'b0, 1'b1);
    add_branch(1'b0, res_not_taken, 32'h200, 32'h800, 1'b1, 32'h800);
    add_idle(2, 1'b0, 1'b1);
    add_branch(1'b0, res_not_taken, 32'h1fc, '0, 1'b1, 32'h300); // back to 0x200
    add_idle(3, 1'b0, 1'b1);
    add_branch(1'b0, res_taken, 32'h300, 32'h200, 1'b1, 32'h200);
    add_branch(1'b0, res_not_taken, 32'h400, '0, 1'b0, '0);
    add_idle(2, 1'b0, 1'b0);
    add_branch(1'b0, res_taken, 32'h300, 32'h900, 1'b1, 32'h200); // wrong target
    add_idle(1, 1'b1, 1'b1);
    add_idle(2, 1'b1, 1'b0);
    add_idle(2, 1'b0, 1'b0);
    for (int i = 0; i < 9; i++) begin
      add_branch(i > 0, res_taken, 32'h1000 + 32'h10 * i, 32'h2000 + 32'h40 * i, 1'b0, '0);
    end
    add_idle(2, 1'b0, 1'b1);
    add_branch(1'b0, res_taken, 32'h1080, 32'h1000, 1'b0, '0); // first one is gone
    add_idle(3, 1'b0, 1'b1);
    for (int j = 1; j < 8; j++) begin
      add_branch(j > 1, res_taken, 32'h1080, 32'h1000 + 32'h10 * j, 1'b1,
                 32'h1000 + 32'h10 * (j - 1));
    end
    add_idle(3, 1'b0, 1'b1);
    add_branch(1'b0, res_taken, 32'h1070, 32'h1080, 1'b1, 32'h21c0);
    add_idle(4, 1'b0, 1'b1);
    add_filler(2);
  endtask

  task automatic reset_model();
    m_pc        = `RESET_PC;
    m_ptr       = 0;
    m_res_valid = 1'b0;
    m_res       = '0;
    for (int i = 0; i < `BTB_ENTRIES; i++) begin
      m_keys[i]    = '0;
      m_targets[i] = '0;
      m_valid[i]   = 1'b0;
    end
  endtask

  task automatic lookup_model(input addr_t lpc, output logic hit, output addr_t tgt);
    logic found;
    found = 1'b0;
    hit   = 1'b0;
    tgt   = '0;
    for (int i = 0; i < `BTB_ENTRIES; i++) begin
      if (!found && m_keys[i] == lpc) begin
        found = 1'b1;
        hit   = m_valid[i];
        tgt   = m_targets[i];
      end
    end
  endtask

  task automatic write_model(input addr_t wpc, input addr_t wtgt, input logic taken);
    int idx;
    idx = -1;
    for (int i = 0; i < `BTB_ENTRIES; i++) begin
      if (idx < 0 && m_keys[i] == wpc) idx = i;
    end
    if (idx < 0) begin
      idx         = m_ptr;
      m_keys[idx] = wpc;
      m_ptr       = (m_ptr + 1) % `BTB_ENTRIES;
    end
    m_targets[idx] = wtgt;
    m_valid[idx]   = taken;
  endtask

  task automatic expected_redirect(output logic rd, output addr_t rpc);
    rd  = 1'b0;
    rpc = '0;
    if (m_res_valid && m_res.kind == res_taken) begin
      rpc = m_res.target;
      rd  = !m_res.pred_taken || (m_res.pred_target != m_res.target);
    end else if (m_res_valid && m_res.kind == res_not_taken) begin
      rpc = m_res.pc + `ADDR_WIDTH'd4;
      rd  = m_res.pred_taken;
    end
  endtask

  task automatic report_mismatch(input string name, input addr_t exp, input addr_t got);
    $display("mismatch at %0d ns: %s expected %h, got %h", $time, name, exp, got);
    errors++;
  endtask

  task automatic check_outputs(input logic row_redirect);
    logic  exp_taken;
    addr_t exp_target;
    logic  exp_rd;
    addr_t exp_rpc;
    lookup_model(m_pc, exp_taken, exp_target);
    expected_redirect(exp_rd, exp_rpc);
    assert (exp_rd == row_redirect) else begin
      $display("table row at %0d ns expects redirect %0b but the model predicts %0b",
               $time, row_redirect, exp_rd);
      errors++;
    end
    assert (pc === m_pc) else report_mismatch("pc", m_pc, pc);
    assert (pred_taken === exp_taken) else report_mismatch("pred_taken", exp_taken, pred_taken);
    assert (redirect === exp_rd) else report_mismatch("redirect", exp_rd, redirect);
    if (exp_taken) begin
      assert (pred_target === exp_target)
        else report_mismatch("pred_target", exp_target, pred_target);
    end
    if (exp_rd) begin
      assert (redirect_pc === exp_rpc)
        else report_mismatch("redirect_pc", exp_rpc, redirect_pc);
    end
  endtask

  // state as it stands after the next rising edge
  task automatic advance_model(input row_t r);
    logic  hit;
    addr_t tgt;
    logic  rd;
    addr_t rpc;
    lookup_model(m_pc, hit, tgt);
    expected_redirect(rd, rpc);
    if (rd) begin
      m_pc = rpc;
    end else if (!r.stall) begin
      m_pc = hit ? tgt : m_pc + `ADDR_WIDTH'd4;
    end
    if (m_res_valid && m_res.kind != res_none) begin
      write_model(m_res.pc, m_res.target, m_res.kind == res_taken);
    end
    m_res_valid = r.valid;
    if (r.valid) m_res = r;
  endtask

  task automatic drive_row(input row_t r);
    stall               = r.stall;
    resolve_valid       = r.valid;
    resolve_kind        = r.kind;
    resolve_pc          = r.pc;
    resolve_target      = r.target;
    resolve_pred_taken  = r.pred_taken;
    resolve_pred_target = r.pred_target;
  endtask

  task automatic wait_redirect_clear();
    int cycles;
    cycles = 0;
    while (redirect === 1'b1 && cycles < WAIT_LIMIT) begin
      @(negedge clk);
      cycles++;
    end
    if (redirect === 1'b1) begin
      $display("timeout: redirect still high after %0d cycles", WAIT_LIMIT);
      errors++;
    end
  endtask

  initial begin
    int    seed_ret;
    row_t  quiet;
    clk                 = 1'b0;
    reset               = 1'b1;
    stall               = 1'b0;
    resolve_valid       = 1'b0;
    resolve_kind        = res_none;
    resolve_pc          = '0;
    resolve_target      = '0;
    resolve_pred_taken  = 1'b0;
    resolve_pred_target = '0;
    errors              = 0;
    quiet               = '0;
    seed_ret = $urandom(70);
    build_table();
    reset_model();
    repeat (RESET_CYCLES) @(posedge clk);
    #1;
    reset = 1'b0;
    foreach (rows[i]) begin
      drive_row(rows[i]);
      @(negedge clk);
      check_outputs(rows[i].exp_redirect);
      advance_model(rows[i]);
      @(posedge clk);
      #1;
    end
    drive_row(quiet);
    wait_redirect_clear();
    $display("errors: %0d testbench checks, %0d bound assertion failures",
             errors, uut.u_chk.fail_count);
    if (errors == 0 && uut.u_chk.fail_count == 0) begin
      $display("Result: PASSED");
    end else begin
      $display("Result: FAILED");
    end
    $finish;
  end

endmodule

/* include/fetch_consts.svh */
`ifndef FETCH_CONSTS_SVH
`define FETCH_CONSTS_SVH

// width of fetch pc and branch targets
`define ADDR_WIDTH 32

// branch target buffer depth, replacement pointer wraps here
`define BTB_ENTRIES 8

// nonzero, never matches the zeroed keys after reset
`define RESET_PC 32'h100

`endif

/* rtl/branch_update.sv */
`include "fetch_consts.svh"

module branch_update (
  input  logic                     clk,
  input  logic                     reset,
  input  logic                     resolve_valid,
  input  fetch_pkg::resolve_kind_e resolve_kind,
  input  fetch_pkg::addr_t         resolve_pc,
  input  fetch_pkg::addr_t         resolve_target,
  input  fetch_pkg::addr_t         resolve_pred_target,
  input  logic                     resolve_pred_taken,
  btb_if.update                    bus,
  output logic                     redirect,
  output fetch_pkg::addr_t         redirect_pc
);
  import fetch_pkg::*;

  logic          res_valid_q;
  resolve_kind_e res_kind_q;
  addr_t         res_pc_q;
  addr_t         res_target_q;
  addr_t         res_pred_target_q;
  logic          res_pred_taken_q;

  logic          is_taken;
  logic          is_not_taken;
  logic          mispredict;

  always_ff @(posedge clk) begin
    if (reset) begin
      res_valid_q <= 1'b0;
    end else begin
      res_valid_q <= resolve_valid;
    end
  end

  always_ff @(posedge clk) begin
    if (resolve_valid) begin
      res_kind_q        <= resolve_kind;
      res_pc_q          <= resolve_pc;
      res_target_q      <= resolve_target;
      res_pred_target_q <= resolve_pred_target;
      res_pred_taken_q  <= resolve_pred_taken;
    end
  end

  assign is_taken     = res_valid_q && (res_kind_q == res_taken);
  assign is_not_taken = res_valid_q && (res_kind_q == res_not_taken);

  // wrong direction, or taken to the wrong place
  assign mispredict = (is_taken && (!res_pred_taken_q || res_pred_target_q != res_target_q)) ||
                      (is_not_taken && res_pred_taken_q);

  assign bus.write        = is_taken || is_not_taken;
  assign bus.write_pc     = res_pc_q;
  assign bus.write_target = res_target_q;
  assign bus.write_taken  = is_taken;

  assign redirect    = mispredict;
  assign redirect_pc = is_taken ? res_target_q : res_pc_q + `ADDR_WIDTH'd4; // fall-through

endmodule

/* rtl/btb_if.sv */
interface btb_if;
  import fetch_pkg::*;

  addr_t lookup_pc;
  addr_t target;
  logic  target_valid;

  logic  write;        // one-cycle strobe
  addr_t write_pc;
  addr_t write_target;
  logic  write_taken;

  modport fetch (
    output lookup_pc,
    input  target,
    input  target_valid
  );

  modport update (
    output write,
    output write_pc,
    output write_target,
    output write_taken
  );

  modport btb (
    input  lookup_pc,
    output target,
    output target_valid,
    input  write,
    input  write_pc,
    input  write_target,
    input  write_taken
  );

endinterface

/* rtl/btb_lut.sv */
`include "fetch_consts.svh"

module btb_lut (
  input logic clk,
  input logic reset,
  btb_if.btb  bus
);
  import fetch_pkg::*;

  localparam int PTR_W = $clog2(`BTB_ENTRIES);

  addr_t                   keys    [`BTB_ENTRIES];
  addr_t                   targets [`BTB_ENTRIES];
  logic [`BTB_ENTRIES-1:0] valid;
  logic [PTR_W-1:0]        ptr;     // round-robin victim
  logic [PTR_W-1:0]        ptr_next;

  logic                    write_hit;
  logic [PTR_W-1:0]        write_idx;
  logic [PTR_W-1:0]        write_sel;

  // combinational lookup, lowest matching entry wins
  always_comb begin
    bus.target       = '0;
    bus.target_valid = 1'b0;
    for (int i = `BTB_ENTRIES - 1; i >= 0; i--) begin
      if (keys[i] == bus.lookup_pc) begin
        bus.target       = targets[i];
        bus.target_valid = valid[i];
      end
    end
  end

  // is the written pc already held somewhere
  always_comb begin
    write_hit = 1'b0;
    write_idx = '0;
    for (int i = `BTB_ENTRIES - 1; i >= 0; i--) begin
      if (keys[i] == bus.write_pc) begin
        write_hit = 1'b1;
        write_idx = PTR_W'(i);
      end
    end
  end

  assign write_sel = write_hit ? write_idx : ptr;
  assign ptr_next  = (ptr == PTR_W'(`BTB_ENTRIES - 1)) ? '0 : ptr + 1'b1;

  always_ff @(posedge clk) begin
    if (reset) begin
      for (int i = 0; i < `BTB_ENTRIES; i++) begin
        keys[i] <= '0;
      end
      valid <= '0;
      ptr   <= '0;
    end else if (bus.write) begin
      valid[write_sel] <= bus.write_taken; // not taken clears the prediction
      if (!write_hit) begin
        keys[ptr] <= bus.write_pc;
        ptr       <= ptr_next;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (bus.write) begin
      targets[write_sel] <= bus.write_target;
    end
  end

endmodule

/* rtl/fetch_pc_gen.sv */
`include "fetch_consts.svh"

module fetch_pc_gen (
  input  logic             clk,
  input  logic             reset,
  input  logic             stall,
  input  logic             redirect,
  input  fetch_pkg::addr_t redirect_pc,
  btb_if.fetch             bus,
  output fetch_pkg::addr_t pc,
  output logic             pred_taken,
  output fetch_pkg::addr_t pred_target
);
  import fetch_pkg::*;

  addr_t pc_next;
  addr_t pc_seq;

  assign pc_seq = pc + `ADDR_WIDTH'd4;

  // redirect beats stall, stall beats prediction
  always_comb begin
    if (redirect) begin
      pc_next = redirect_pc;
    end else if (stall) begin
      pc_next = pc;
    end else if (bus.target_valid) begin
      pc_next = bus.target;
    end else begin
      pc_next = pc_seq;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      pc <= `RESET_PC;
    end else begin
      pc <= pc_next;
    end
  end

  assign bus.lookup_pc = pc;

  // prediction for the current pc, travels with the instruction
  assign pred_taken  = bus.target_valid;
  assign pred_target = bus.target;

endmodule

/* rtl/fetch_pkg.sv */
`include "fetch_consts.svh"

package fetch_pkg;

  // one word, used for pcs and targets
  typedef logic [`ADDR_WIDTH-1:0] addr_t;

  // outcome of a resolved branch coming back from execute
  typedef enum logic [1:0] {
    res_none      = 2'd0, // slot carries no branch
    res_taken     = 2'd1,
    res_not_taken = 2'd2
  } resolve_kind_e;

endpackage

/* rtl/fetch_top.sv */
module fetch_top (
  input  logic                     clk,
  input  logic                     reset,
  input  logic                     stall,
  input  logic                     resolve_valid,
  input  fetch_pkg::resolve_kind_e resolve_kind,
  input  fetch_pkg::addr_t         resolve_pc,
  input  fetch_pkg::addr_t         resolve_target,
  input  logic                     resolve_pred_taken,
  input  fetch_pkg::addr_t         resolve_pred_target,
  output fetch_pkg::addr_t         pc,
  output logic                     pred_taken,
  output fetch_pkg::addr_t         pred_target,
  output logic                     redirect,
  output fetch_pkg::addr_t         redirect_pc
);

  btb_if btb_bus ();

  btb_lut u_btb_lut (
    .clk   (clk),
    .reset (reset),
    .bus   (btb_bus.btb)
  );

  fetch_pc_gen u_fetch_pc_gen (
    .clk         (clk),
    .reset       (reset),
    .stall       (stall),
    .redirect    (redirect),
    .redirect_pc (redirect_pc),
    .bus         (btb_bus.fetch),
    .pc          (pc),
    .pred_taken  (pred_taken),
    .pred_target (pred_target)
  );

  // resolutions come back from a later stage
  branch_update u_branch_update (
    .clk                 (clk),
    .reset               (reset),
    .resolve_valid       (resolve_valid),
    .resolve_kind        (resolve_kind),
    .resolve_pc          (resolve_pc),
    .resolve_target      (resolve_target),
    .resolve_pred_target (resolve_pred_target),
    .resolve_pred_taken  (resolve_pred_taken),
    .bus                 (btb_bus.update),
    .redirect            (redirect),
    .redirect_pc         (redirect_pc)
  );

endmodule

/* run.sh */
#!/bin/sh
# build and run fetch_tb with verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log
BIN=fetch_sim

verilator --binary --timing --assert \
  -f sources.f \
  --top-module fetch_tb \
  -o "$BIN"
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

./obj_dir/"$BIN" +verilator+error+limit+1000 > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "Result: PASSED" "$LOG"; then
  echo "run passed"
  exit 0
fi
echo "run failed"
exit 1

/* sources.f */
+incdir+include
rtl/fetch_pkg.sv
rtl/btb_if.sv
rtl/btb_lut.sv
rtl/fetch_pc_gen.sv
rtl/branch_update.sv
rtl/fetch_top.sv
dv/fetch_chk.sv
dv/fetch_tb.sv
